// File: hdl/exec_config.svh
//////////////////////////////////////////////////////////////////////
// Execution lane configuration
// Data width, result latency, tag and ROB index widths, and the
// poison values that flag an illegal operand select or function
//////////////////////////////////////////////////////////////////////
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width in bits
`define EXEC_XLEN       32

// Cycles from accept edge to result valid, at least 1
`define EXEC_LAT        2

// Physical register tag and reorder buffer index widths
`define EXEC_TAG_W      6
`define EXEC_ROB_W      5

// Seen on an operand when its select is not a legal code
`define EXEC_POISON_OPA 32'hdeadfbac
`define EXEC_POISON_OPB 32'hfacefeed

// Seen on a unit result for a function outside that unit
`define EXEC_POISON_RES 32'hfacebeec

`endif

// File: hdl/exec_pkg.sv
//////////////////////////////////////////////////////////////////////
// Execution lane package
// Word and index types, operand select and function encodings,
// and the issue and result records of the lane
//////////////////////////////////////////////////////////////////////
`include "exec_config.svh"

package exec_pkg;

    // Data word and raw RV32 instruction
    typedef logic [`EXEC_XLEN-1:0]  word_t;
    typedef logic [31:0]            inst_t;

    // Rename and ROB bookkeeping
    typedef logic [`EXEC_TAG_W-1:0] tag_t;
    typedef logic [`EXEC_ROB_W-1:0] rob_idx_t;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    // Operand B source, codes 6 and 7 are illegal
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    // Shared function code for the ALU and the multiplier
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    // Which unit produces the broadcast value
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MULT   = 2'd1,
        UNIT_BRANCH = 2'd2
    } unit_kind_e;

    // Instruction as it leaves the issue stage
    typedef struct packed {
        word_t      pc;
        word_t      npc;
        inst_t      inst;
        word_t      rs1_value;
        word_t      rs2_value;
        opa_sel_e   opa_sel;
        opb_sel_e   opb_sel;
        alu_func_e  alu_func;
        unit_kind_e unit;
        logic       cond_br;
        logic       uncond_br;
        tag_t       tag;
        rob_idx_t   rob_idx;
    } issue_inst_t;

    // Record driven onto the broadcast bus
    typedef struct packed {
        word_t      pc;
        word_t      rd_value;
        logic       write_reg;
        logic       is_branch;
        logic       br_taken;
        word_t      br_target;
        tag_t       tag;
        rob_idx_t   rob_idx;
    } exec_result_t;

endpackage

// File: hdl/exec_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Execution lane control
// Holds the accepted instruction, tracks it through a LAT deep
// valid shift register, stalls on broadcast back-pressure and
// drops everything on a flush
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_ctrl #(
    parameter int LAT = `EXEC_LAT
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  issue_valid_i,
    input  exec_pkg::issue_inst_t issue_inst_i,
    input  logic                  broadcast_i,
    input  logic                  flush_i,
    output logic                  issue_ready_o,
    output exec_pkg::issue_inst_t held_inst_o,
    output logic                  result_valid_o
);

    logic [LAT-1:0] valid_sh;
    logic [LAT-1:0] valid_next;
    logic           ex_start;
    logic           ex_end;
    logic           stall;

    //////////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////////

    // Oldest stage of the shift register is the result strobe
    assign result_valid_o = valid_sh[LAT-1];

    // Result leaves on a broadcast, waits otherwise
    assign ex_end = result_valid_o && broadcast_i;
    assign stall  = result_valid_o && !broadcast_i;

    // Room for one more when empty or when the result drains now
    assign issue_ready_o = (valid_sh == '0) || ex_end;
    assign ex_start      = issue_valid_i && issue_ready_o;

    //////////////////////////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////////////////////////

    // Loaded only on accept, so it stays put while stalled
    always_ff @(posedge clk_i) begin
        if (ex_start) begin
            held_inst_o <= issue_inst_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Valid shift register
    //////////////////////////////////////////////////////////////////////

    generate
        if (LAT == 1) begin : g_lat_one
            // Single stage, accept goes straight to the output
            assign valid_next = ex_start;
        end else begin : g_lat_multi
            assign valid_next = {valid_sh[LAT-2:0], ex_start};
        end
    endgenerate

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_sh <= '0;
        // Flush kills in-flight work and any same-cycle accept
        end else if (flush_i) begin
            valid_sh <= '0;
        // Bus busy, freeze
        end else if (!stall) begin
            valid_sh <= valid_next;
        end
    end

endmodule

// File: hdl/operand_select.sv
//////////////////////////////////////////////////////////////////////
// Operand select
// Picks operand A and operand B for the held instruction and
// decodes the sign-extended RV32 immediates
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module operand_select (
    input  exec_pkg::issue_inst_t inst_i,
    output exec_pkg::word_t       opa_o,
    output exec_pkg::word_t       opb_o
);

    exec_pkg::word_t imm_i;
    exec_pkg::word_t imm_s;
    exec_pkg::word_t imm_b;
    exec_pkg::word_t imm_u;
    exec_pkg::word_t imm_j;

    // Immediate fields, sign bit is always inst[31]
    assign imm_i = {{20{inst_i.inst[31]}}, inst_i.inst[31:20]};
    assign imm_s = {{20{inst_i.inst[31]}}, inst_i.inst[31:25], inst_i.inst[11:7]};
    // Branch offset is in half words
    assign imm_b = {{19{inst_i.inst[31]}}, inst_i.inst[31], inst_i.inst[7],
                    inst_i.inst[30:25], inst_i.inst[11:8], 1'b0};
    assign imm_u = {inst_i.inst[31:12], 12'b0};
    // Jump offset, scrambled bit order as per the ISA
    assign imm_j = {{11{inst_i.inst[31]}}, inst_i.inst[31], inst_i.inst[19:12],
                    inst_i.inst[20], inst_i.inst[30:21], 1'b0};

    // Operand A mux
    always_comb begin
        opa_o = `EXEC_POISON_OPA;
        case (inst_i.opa_sel)
            exec_pkg::OPA_IS_RS1:  opa_o = inst_i.rs1_value;
            exec_pkg::OPA_IS_NPC:  opa_o = inst_i.npc;
            exec_pkg::OPA_IS_PC:   opa_o = inst_i.pc;
            exec_pkg::OPA_IS_ZERO: opa_o = '0;
        endcase
    end

    // Operand B mux, poison shows up for codes 6 and 7
    always_comb begin
        opb_o = `EXEC_POISON_OPB;
        case (inst_i.opb_sel)
            exec_pkg::OPB_IS_RS2:   opb_o = inst_i.rs2_value;
            exec_pkg::OPB_IS_I_IMM: opb_o = imm_i;
            exec_pkg::OPB_IS_S_IMM: opb_o = imm_s;
            exec_pkg::OPB_IS_B_IMM: opb_o = imm_b;
            exec_pkg::OPB_IS_U_IMM: opb_o = imm_u;
            exec_pkg::OPB_IS_J_IMM: opb_o = imm_j;
        endcase
    end

endmodule

// File: hdl/int_alu.sv
//////////////////////////////////////////////////////////////////////
// Integer ALU
// Add, subtract, logic ops, set-less-than and shifts, all
// combinational
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module int_alu (
    input  exec_pkg::word_t     opa_i,
    input  exec_pkg::word_t     opb_i,
    input  exec_pkg::alu_func_e func_i,
    output exec_pkg::word_t     result_o
);

    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    assign lt_signed   = $signed(opa_i) < $signed(opb_i);
    assign lt_unsigned = opa_i < opb_i;
    // Only the low five bits count for RV32 shifts
    assign shamt       = opb_i[4:0];

    always_comb begin
        case (func_i)
            exec_pkg::ALU_ADD:  result_o = opa_i + opb_i;
            exec_pkg::ALU_SUB:  result_o = opa_i - opb_i;
            exec_pkg::ALU_AND:  result_o = opa_i & opb_i;
            exec_pkg::ALU_OR:   result_o = opa_i | opb_i;
            exec_pkg::ALU_XOR:  result_o = opa_i ^ opb_i;
            exec_pkg::ALU_SLT:  result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            exec_pkg::ALU_SLTU: result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            exec_pkg::ALU_SLL:  result_o = opa_i << shamt;
            exec_pkg::ALU_SRL:  result_o = opa_i >> shamt;
            // Sign fill from opa
            exec_pkg::ALU_SRA:  result_o = $signed(opa_i) >>> shamt;
            // Multiply codes land here
            default:            result_o = `EXEC_POISON_RES;
        endcase
    end

endmodule

// File: hdl/int_mult.sv
//////////////////////////////////////////////////////////////////////
// Integer multiplier
// Full width products for MUL, MULH, MULHSU and MULHU
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module int_mult (
    input  exec_pkg::word_t     opa_i,
    input  exec_pkg::word_t     opb_i,
    input  exec_pkg::alu_func_e func_i,
    output exec_pkg::word_t     result_o
);

    logic signed [2*`EXEC_XLEN-1:0] prod_ss;
    logic signed [2*`EXEC_XLEN-1:0] prod_su;
    logic        [2*`EXEC_XLEN-1:0] prod_uu;

    // Operands widened by hand so every product is exact
    assign prod_ss = $signed({{`EXEC_XLEN{opa_i[`EXEC_XLEN-1]}}, opa_i})
                   * $signed({{`EXEC_XLEN{opb_i[`EXEC_XLEN-1]}}, opb_i});
    assign prod_su = $signed({{`EXEC_XLEN{opa_i[`EXEC_XLEN-1]}}, opa_i})
                   * $signed({{`EXEC_XLEN{1'b0}}, opb_i});
    assign prod_uu = {{`EXEC_XLEN{1'b0}}, opa_i} * {{`EXEC_XLEN{1'b0}}, opb_i};

    always_comb begin
        case (func_i)
            // Low half is the same for every signedness
            exec_pkg::ALU_MUL:    result_o = prod_ss[`EXEC_XLEN-1:0];
            exec_pkg::ALU_MULH:   result_o = prod_ss[2*`EXEC_XLEN-1:`EXEC_XLEN];
            exec_pkg::ALU_MULHSU: result_o = prod_su[2*`EXEC_XLEN-1:`EXEC_XLEN];
            exec_pkg::ALU_MULHU:  result_o = prod_uu[2*`EXEC_XLEN-1:`EXEC_XLEN];
            default:              result_o = `EXEC_POISON_RES;
        endcase
    end

endmodule

// File: hdl/branch_eval.sv
//////////////////////////////////////////////////////////////////////
// Branch evaluation
// Tests the funct3 condition on rs1 and rs2 and gives the
// final taken decision
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_eval (
    input  exec_pkg::word_t rs1_i,
    input  exec_pkg::word_t rs2_i,
    input  logic [2:0]      funct3_i,
    input  logic            cond_br_i,
    input  logic            uncond_br_i,
    output logic            taken_o
);

    logic cond;

    always_comb begin
        // funct3 codes 2 and 3 are not branches
        cond = 1'b0;
        case (funct3_i)
            3'b000: cond = rs1_i == rs2_i;                    // BEQ
            3'b001: cond = rs1_i != rs2_i;                    // BNE
            3'b100: cond = $signed(rs1_i) <  $signed(rs2_i);  // BLT
            3'b101: cond = $signed(rs1_i) >= $signed(rs2_i);  // BGE
            3'b110: cond = rs1_i <  rs2_i;                    // BLTU
            3'b111: cond = rs1_i >= rs2_i;                    // BGEU
            default: cond = 1'b0;
        endcase
    end

    // Jumps always go, branches only on a true condition
    assign taken_o = uncond_br_i || (cond_br_i && cond);

endmodule

// File: hdl/result_pack.sv
//////////////////////////////////////////////////////////////////////
// Result packing
// Assembles the broadcast record from the unit results, keyed on
// the unit kind of the held instruction
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module result_pack (
    input  exec_pkg::issue_inst_t  inst_i,
    input  exec_pkg::word_t        alu_res_i,
    input  exec_pkg::word_t        mult_res_i,
    input  logic                   br_taken_i,
    output exec_pkg::exec_result_t result_o
);

    always_comb begin
        // Bookkeeping fields pass through untouched
        result_o.pc        = inst_i.pc;
        result_o.tag       = inst_i.tag;
        result_o.rob_idx   = inst_i.rob_idx;
        // Non-branch defaults
        result_o.rd_value  = '0;
        result_o.write_reg = 1'b0;
        result_o.is_branch = 1'b0;
        result_o.br_taken  = 1'b0;
        result_o.br_target = '0;
        case (inst_i.unit)
            exec_pkg::UNIT_ALU: begin
                result_o.rd_value  = alu_res_i;
                result_o.write_reg = 1'b1;
            end
            exec_pkg::UNIT_MULT: begin
                result_o.rd_value  = mult_res_i;
                result_o.write_reg = 1'b1;
            end
            exec_pkg::UNIT_BRANCH: begin
                // Link value, written back only for jumps
                result_o.rd_value  = inst_i.npc;
                result_o.write_reg = inst_i.uncond_br;
                result_o.is_branch = 1'b1;
                result_o.br_taken  = br_taken_i;
                // ALU computes pc or rs1 plus offset
                result_o.br_target = alu_res_i;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/exec_unit.sv
//////////////////////////////////////////////////////////////////////
// Execution lane top
// One issue slot feeding the ALU, multiplier and branch logic,
// with a single result on the broadcast bus
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module exec_unit (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   issue_valid_i,
    input  exec_pkg::issue_inst_t  issue_inst_i,
    input  logic                   broadcast_i,
    input  logic                   flush_i,
    output logic                   issue_ready_o,
    output logic                   result_valid_o,
    output exec_pkg::exec_result_t result_o
);

    exec_pkg::issue_inst_t held_inst;
    exec_pkg::word_t       opa;
    exec_pkg::word_t       opb;
    exec_pkg::word_t       alu_res;
    exec_pkg::word_t       mult_res;
    logic                  br_taken;

    // Only sequential block, sets the latency
    exec_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_inst_i   (issue_inst_i),
        .broadcast_i    (broadcast_i),
        .flush_i        (flush_i),
        .issue_ready_o  (issue_ready_o),
        .held_inst_o    (held_inst),
        .result_valid_o (result_valid_o)
    );

    operand_select u_opsel (
        .inst_i (held_inst),
        .opa_o  (opa),
        .opb_o  (opb)
    );

    int_alu u_alu (
        .opa_i    (opa),
        .opb_i    (opb),
        .func_i   (held_inst.alu_func),
        .result_o (alu_res)
    );

    int_mult u_mult (
        .opa_i    (opa),
        .opb_i    (opb),
        .func_i   (held_inst.alu_func),
        .result_o (mult_res)
    );

    // Condition uses the raw registers, funct3 from inst[14:12]
    branch_eval u_br (
        .rs1_i       (held_inst.rs1_value),
        .rs2_i       (held_inst.rs2_value),
        .funct3_i    (held_inst.inst[14:12]),
        .cond_br_i   (held_inst.cond_br),
        .uncond_br_i (held_inst.uncond_br),
        .taken_o     (br_taken)
    );

    result_pack u_pack (
        .inst_i     (held_inst),
        .alu_res_i  (alu_res),
        .mult_res_i (mult_res),
        .br_taken_i (br_taken),
        .result_o   (result_o)
    );

endmodule

// File: verification/exec_unit_assertions.sv
//////////////////////////////////////////////////////////////////////
// Execution lane checker
// Reference model of the lane built from the issue port, with
// concurrent assertions on timing, handshakes and result fields
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_unit_assertions (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   issue_valid_i,
    input exec_pkg::issue_inst_t  issue_inst_i,
    input logic                   broadcast_i,
    input logic                   flush_i,
    input logic                   issue_ready_o,
    input logic                   result_valid_o,
    input exec_pkg::exec_result_t result_o
);

    int                     fail_count;
    logic                   pending;
    int unsigned            age;
    logic                   model_valid;
    exec_pkg::exec_result_t exp_res;

    initial fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic exec_pkg::exec_result_t expect_result(exec_pkg::issue_inst_t t);
        exec_pkg::exec_result_t r;
        exec_pkg::word_t        a;
        exec_pkg::word_t        b;
        exec_pkg::word_t        ex;
        logic [31:0]            w;
        longint                 p;
        logic                   cond;
        logic                   is_mul;
        w = t.inst;
        case (t.opa_sel)
            exec_pkg::OPA_IS_RS1: a = t.rs1_value;
            exec_pkg::OPA_IS_NPC: a = t.npc;
            exec_pkg::OPA_IS_PC:  a = t.pc;
            default:              a = '0;
        endcase
        // Immediates sign extended from their top field bit
        case (t.opb_sel)
            exec_pkg::OPB_IS_RS2:   b = t.rs2_value;
            exec_pkg::OPB_IS_I_IMM: b = $signed(w[31:20]);
            exec_pkg::OPB_IS_S_IMM: b = $signed({w[31:25], w[11:7]});
            exec_pkg::OPB_IS_B_IMM: b = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            exec_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'h000};
            exec_pkg::OPB_IS_J_IMM: b = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default:                b = `EXEC_POISON_OPB;
        endcase
        case (t.alu_func)
            exec_pkg::ALU_ADD:  ex = a + b;
            exec_pkg::ALU_SUB:  ex = a - b;
            exec_pkg::ALU_AND:  ex = a & b;
            exec_pkg::ALU_OR:   ex = a | b;
            exec_pkg::ALU_XOR:  ex = a ^ b;
            exec_pkg::ALU_SLT:  ex = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::ALU_SLTU: ex = (a < b) ? 32'd1 : 32'd0;
            exec_pkg::ALU_SLL:  ex = a << b[4:0];
            exec_pkg::ALU_SRL:  ex = a >> b[4:0];
            exec_pkg::ALU_SRA:  ex = $signed(a) >>> b[4:0];
            exec_pkg::ALU_MUL:  ex = a * b;
            exec_pkg::ALU_MULH: begin
                p  = longint'($signed(a)) * longint'($signed(b));
                ex = p[63:32];
            end
            exec_pkg::ALU_MULHSU: begin
                p  = longint'($signed(a)) * longint'({32'h0, b});
                ex = p[63:32];
            end
            exec_pkg::ALU_MULHU: begin
                p  = {32'h0, a} * {32'h0, b};
                ex = p[63:32];
            end
            default: ex = `EXEC_POISON_RES;
        endcase
        // Each unit poisons the other unit's functions
        is_mul = t.alu_func inside {exec_pkg::ALU_MUL, exec_pkg::ALU_MULH,
                                    exec_pkg::ALU_MULHSU, exec_pkg::ALU_MULHU};
        if (is_mul != (t.unit == exec_pkg::UNIT_MULT)) begin
            ex = `EXEC_POISON_RES;
        end
        case (w[14:12])
            3'b000:  cond = t.rs1_value == t.rs2_value;
            3'b001:  cond = t.rs1_value != t.rs2_value;
            3'b100:  cond = $signed(t.rs1_value) < $signed(t.rs2_value);
            3'b101:  cond = !($signed(t.rs1_value) < $signed(t.rs2_value));
            3'b110:  cond = t.rs1_value < t.rs2_value;
            3'b111:  cond = !(t.rs1_value < t.rs2_value);
            default: cond = 1'b0;
        endcase
        r         = '0;
        r.pc      = t.pc;
        r.tag     = t.tag;
        r.rob_idx = t.rob_idx;
        if (t.unit == exec_pkg::UNIT_BRANCH) begin
            r.rd_value  = t.npc;
            r.write_reg = t.uncond_br;
            r.is_branch = 1'b1;
            r.br_taken  = t.uncond_br || (t.cond_br && cond);
            r.br_target = ex;
        end else if (t.unit == exec_pkg::UNIT_ALU || t.unit == exec_pkg::UNIT_MULT) begin
            r.rd_value  = ex;
            r.write_reg = 1'b1;
        end
        return r;
    endfunction

    // Result due on the bus for the one item in flight
    assign model_valid = pending && (age == `EXEC_LAT);

    // Age counts edges since the accept
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            pending <= 1'b0;
            age     <= 0;
        end else if (issue_valid_i && issue_ready_o) begin
            pending <= 1'b1;
            age     <= 1;
            exp_res <= expect_result(issue_inst_i);
        end else if (model_valid && broadcast_i) begin
            pending <= 1'b0;
        end else if (pending && age < `EXEC_LAT) begin
            age <= age + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake and timing
    //////////////////////////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk_i)
        rst_i |=> !result_valid_o && issue_ready_o)
        else begin
            fail_count = fail_count + 1;
            $error("Lane not empty and ready after a reset edge");
        end

    a_valid_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o == model_valid)
        else begin
            fail_count = fail_count + 1;
            $error("Error: result_valid_o is %h, expected %h", $sampled(result_valid_o),
                   $sampled(model_valid));
        end

    a_ready_rule: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_ready_o == (!pending || (model_valid && broadcast_i)))
        else begin
            fail_count = fail_count + 1;
            $error("Error: issue_ready_o is %h, expected %h", $sampled(issue_ready_o),
                   $sampled(!pending || (model_valid && broadcast_i)));
        end

    // Stalled result holds still
    a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        model_valid && !broadcast_i && !flush_i |=> result_valid_o && $stable(result_o))
        else begin
            fail_count = fail_count + 1;
            $error("Result dropped or changed while the broadcast bus was stalled");
        end

    a_flush_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |=> issue_ready_o)
        else begin
            fail_count = fail_count + 1;
            $error("Lane not ready on the cycle after a flush");
        end

    //////////////////////////////////////////////////////////////////////
    // Result fields
    //////////////////////////////////////////////////////////////////////

    a_rd_value: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> result_o.rd_value == exp_res.rd_value)
        else begin
            fail_count = fail_count + 1;
            $error("Error: result_o.rd_value is %h, expected %h",
                   $sampled(result_o.rd_value), $sampled(exp_res.rd_value));
        end

    a_branch: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> {result_o.br_taken, result_o.br_target}
                        == {exp_res.br_taken, exp_res.br_target})
        else begin
            fail_count = fail_count + 1;
            $error("Error: result_o.{br_taken,br_target} is %h, expected %h",
                   $sampled({result_o.br_taken, result_o.br_target}),
                   $sampled({exp_res.br_taken, exp_res.br_target}));
        end

    // Flags plus pc, tag and ROB index
    a_bookkeeping: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> {result_o.write_reg, result_o.is_branch, result_o.pc,
                            result_o.tag, result_o.rob_idx}
                        == {exp_res.write_reg, exp_res.is_branch, exp_res.pc,
                            exp_res.tag, exp_res.rob_idx})
        else begin
            fail_count = fail_count + 1;
            $error("Error: result_o.{write_reg,is_branch,pc,tag,rob_idx} is %h, expected %h",
                   $sampled({result_o.write_reg, result_o.is_branch, result_o.pc,
                             result_o.tag, result_o.rob_idx}),
                   $sampled({exp_res.write_reg, exp_res.is_branch, exp_res.pc,
                             exp_res.tag, exp_res.rob_idx}));
        end

endmodule

// File: verification/exec_unit_tb.sv
//////////////////////////////////////////////////////////////////////
// Execution lane testbench
// Drives ALU, multiply, branch, back-pressure and flush traffic;
// the bound checker does the comparing
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_unit_tb;

    localparam int N_TESTS     = 6;
    localparam int N_ITEMS     = 40;
    localparam int WATCHDOG_NS = N_TESTS * N_ITEMS * (`EXEC_LAT + 4) * 10 + 1000;

    logic                   clk_i;
    logic                   rst_i;
    logic                   issue_valid_i;
    exec_pkg::issue_inst_t  issue_inst_i;
    logic                   broadcast_i;
    logic                   flush_i;
    logic                   issue_ready_o;
    logic                   result_valid_o;
    exec_pkg::exec_result_t result_o;

    int                    seed;
    int                    fails_before;
    int                    tests_run;
    int                    tests_failed;
    exec_pkg::issue_inst_t t;
    exec_pkg::word_t       extremes [0:3] = '{32'h8000_0000, 32'h7fff_ffff,
                                              32'hffff_ffff, 32'h0000_0000};
    logic [2:0]            br_f3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    exec_unit UUT (.*);

    bind exec_unit exec_unit_assertions u_checks (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Random instruction, register operands by default
    function automatic exec_pkg::issue_inst_t rand_inst(input exec_pkg::unit_kind_e unit,
                                                        input exec_pkg::alu_func_e func);
        exec_pkg::issue_inst_t r;
        r           = '0;
        r.pc        = $random(seed);
        r.pc[1:0]   = 2'b00;
        r.npc       = r.pc + 4;
        r.inst      = $random(seed);
        r.rs1_value = $random(seed);
        r.rs2_value = $random(seed);
        r.opa_sel   = exec_pkg::OPA_IS_RS1;
        r.opb_sel   = exec_pkg::OPB_IS_RS2;
        r.alu_func  = func;
        r.unit      = unit;
        r.tag       = exec_pkg::tag_t'($random(seed));
        r.rob_idx   = exec_pkg::rob_idx_t'($random(seed));
        return r;
    endfunction

    // Called on a falling edge, returns on the falling edge after accept
    task automatic issue_one(input exec_pkg::issue_inst_t inst);
        issue_valid_i = 1'b1;
        issue_inst_i  = inst;
        do begin
            @(posedge clk_i);
        end while (!issue_ready_o);
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_result();
        while (!result_valid_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic run_item(input exec_pkg::issue_inst_t inst);
        issue_one(inst);
        wait_result();
        @(negedge clk_i);
    endtask

    task automatic close_test(input string name);
        int fails;
        repeat (2) @(negedge clk_i);
        fails        = UUT.u_checks.fail_count - fails_before;
        fails_before = UUT.u_checks.fail_count;
        tests_run    = tests_run + 1;
        if (fails != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %-13s %s, %0d assertion failures", name,
                 (fails == 0) ? "passed" : "failed", fails);
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed          = 32'h63a8;
        fails_before  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_inst_i  = '0;
        broadcast_i   = 1'b1;
        flush_i       = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        close_test("reset");

        // Every opa source against every opb source in the first 24
        for (int i = 0; i < N_ITEMS; i++) begin
            t         = rand_inst(exec_pkg::UNIT_ALU, exec_pkg::alu_func_e'(i % 10));
            t.opa_sel = exec_pkg::opa_sel_e'(i % 4);
            t.opb_sel = exec_pkg::opb_sel_e'((i / 4) % 6);
            run_item(t);
        end
        close_test("alu");

        // Signed extremes first, then random operands
        for (int i = 0; i < N_ITEMS; i++) begin
            t = rand_inst(exec_pkg::UNIT_MULT,
                          exec_pkg::alu_func_e'(exec_pkg::ALU_MUL + i % 4));
            if (i < 16) begin
                t.rs1_value = extremes[i / 4];
                t.rs2_value = extremes[(i + i / 4) % 4];
            end
            run_item(t);
        end
        close_test("multiply");

        for (int i = 0; i < N_ITEMS; i++) begin
            t         = rand_inst(exec_pkg::UNIT_BRANCH, exec_pkg::ALU_ADD);
            t.opa_sel = exec_pkg::OPA_IS_PC;
            if (i % 7 == 6) begin
                t.uncond_br = 1'b1;
                t.opb_sel   = exec_pkg::OPB_IS_J_IMM;
            end else begin
                t.cond_br        = 1'b1;
                t.opb_sel        = exec_pkg::OPB_IS_B_IMM;
                t.inst[14:12]    = br_f3[i % 7];
                // Equal registers now and then
                if (i % 3 == 0) begin
                    t.rs2_value = t.rs1_value;
                end
            end
            run_item(t);
        end
        close_test("branch");

        // Stall two cycles, then take and accept on one edge
        broadcast_i = 1'b0;
        issue_one(rand_inst(exec_pkg::UNIT_ALU, exec_pkg::ALU_XOR));
        for (int i = 0; i < 8; i++) begin
            wait_result();
            repeat (2) @(negedge clk_i);
            issue_valid_i = 1'b1;
            issue_inst_i  = rand_inst(exec_pkg::UNIT_ALU, exec_pkg::alu_func_e'(i % 10));
            broadcast_i   = 1'b1;
            @(negedge clk_i);
            issue_valid_i = 1'b0;
            broadcast_i   = 1'b0;
        end
        broadcast_i = 1'b1;
        wait_result();
        @(negedge clk_i);
        close_test("backpressure");

        // Even items flushed in flight, odd ones flushed on the offer cycle
        for (int i = 0; i < 8; i++) begin
            t = rand_inst(exec_pkg::UNIT_ALU, exec_pkg::ALU_ADD);
            if (i % 2 == 0) begin
                issue_one(t);
            end else begin
                issue_valid_i = 1'b1;
                issue_inst_i  = t;
            end
            flush_i = 1'b1;
            @(negedge clk_i);
            flush_i       = 1'b0;
            issue_valid_i = 1'b0;
            repeat (2) @(negedge clk_i);
        end
        close_test("flush");

        $display("Summary: %0d tests run, %0d failed, %0d assertion failures",
                 tests_run, tests_failed, UUT.u_checks.fail_count);
        if (tests_failed == 0 && UUT.u_checks.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_ctrl.sv
hdl/operand_select.sv
hdl/int_alu.sv
hdl/int_mult.sv
hdl/branch_eval.sv
hdl/result_pack.sv
hdl/exec_unit.sv
verification/exec_unit_assertions.sv
verification/exec_unit_tb.sv
